/* contract_pkg.sv */
package contract_pkg;

	// data word width of the observed core
	localparam int unsigned XLEN = 32;

	// major opcodes the observer classifies
	localparam logic [6:0] OPC_LOAD   = 7'h03;
	localparam logic [6:0] OPC_STORE  = 7'h23;
	localparam logic [6:0] OPC_BRANCH = 7'h63;
	localparam logic [6:0] OPC_OP     = 7'h33;

	// M extension marker inside OPC_OP
	localparam logic [6:0] FUNCT7_MULDIV = 7'h01;

	// plain MUL, the other low funct3 codes are the MULH variants
	localparam logic [2:0] FUNCT3_MUL = 3'b000;

	// I-type view, used for loads
	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	// S-type view, also serves R-type
	// funct7 is imm[11:5] for stores, imm_lo is rd for R-type
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	// one instruction word, two decodings
	typedef union packed {
		i_fmt_t i;
		s_fmt_t s;
	} instr_u;

	// record of one retired instruction
	typedef struct packed {
		logic [XLEN-1:0] pc;
		instr_u          instr;
		logic [XLEN-1:0] rs1_val;
		logic [XLEN-1:0] rs2_val;
	} retire_t;

	typedef enum logic [2:0] {
		OBS_OTHER  = 3'd0,
		OBS_LOAD   = 3'd1,
		OBS_STORE  = 3'd2,
		OBS_BRANCH = 3'd3,
		OBS_MUL    = 3'd4,
		OBS_DIV    = 3'd5
	} obs_kind_e;

	// encoded as funct3[1:0] of loads and stores
	typedef enum logic [1:0] {
		SIZE_BYTE = 2'b00,
		SIZE_HALF = 2'b01,
		SIZE_WORD = 2'b10
	} lsu_size_e;

	// encoded as the branch funct3
	typedef enum logic [2:0] {
		BR_EQ  = 3'b000,
		BR_NE  = 3'b001,
		BR_LT  = 3'b100,
		BR_GE  = 3'b101,
		BR_LTU = 3'b110,
		BR_GEU = 3'b111
	} branch_op_e;

	// stage one contents
	typedef struct packed {
		obs_kind_e       kind;
		lsu_size_e       size;
		branch_op_e      br_op;
		logic [XLEN-1:0] imm;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] rs1_val;
		logic [XLEN-1:0] rs2_val;
	} dec_t;

	// what the contract may see for one instruction
	typedef struct packed {
		obs_kind_e       kind;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] addr;
		logic            split;
		logic            taken;
		logic [XLEN-1:0] operand;
	} obs_t;

endpackage

/* rv_obs_decode.sv */
`timescale 1ns/1ps

module rv_obs_decode (
	input  logic                  clk_i,
	input  logic                  arst_n_i,
	input  logic                  load_i,
	input  contract_pkg::retire_t rec_i,
	output contract_pkg::dec_t    dec_o
);

	contract_pkg::i_fmt_t          i_view;
	contract_pkg::s_fmt_t          s_view;
	contract_pkg::obs_kind_e       kind_d;
	contract_pkg::lsu_size_e       size_d;
	contract_pkg::branch_op_e      br_op_d;
	logic [contract_pkg::XLEN-1:0] imm_d;

	contract_pkg::obs_kind_e       kind_q;
	contract_pkg::lsu_size_e       size_q;
	contract_pkg::branch_op_e      br_op_q;
	logic [contract_pkg::XLEN-1:0] imm_q;
	logic [contract_pkg::XLEN-1:0] pc_q;
	logic [contract_pkg::XLEN-1:0] rs1_q;
	logic [contract_pkg::XLEN-1:0] rs2_q;

	assign i_view = rec_i.instr.i;
	assign s_view = rec_i.instr.s;

	always_comb begin
		kind_d = contract_pkg::OBS_OTHER;
		case (i_view.opcode)
			contract_pkg::OPC_LOAD:  kind_d = contract_pkg::OBS_LOAD;
			contract_pkg::OPC_STORE: kind_d = contract_pkg::OBS_STORE;
			contract_pkg::OPC_BRANCH: begin
				// funct3 010 and 011 are unused encodings
				if (i_view.funct3[2:1] != 2'b01) begin
					kind_d = contract_pkg::OBS_BRANCH;
				end
			end
			contract_pkg::OPC_OP: begin
				if (s_view.funct7 == contract_pkg::FUNCT7_MULDIV) begin
					if (s_view.funct3 == contract_pkg::FUNCT3_MUL) begin
						kind_d = contract_pkg::OBS_MUL;
					end else if (s_view.funct3[2]) begin
						// DIV, DIVU, REM, REMU
						kind_d = contract_pkg::OBS_DIV;
					end
				end
			end
			default: kind_d = contract_pkg::OBS_OTHER;
		endcase
	end

	// immediate only for memory ops, zero otherwise
	always_comb begin
		case (kind_d)
			contract_pkg::OBS_LOAD:
				imm_d = {{(contract_pkg::XLEN-12){i_view.imm12[11]}}, i_view.imm12};
			contract_pkg::OBS_STORE:
				imm_d = {{(contract_pkg::XLEN-12){s_view.funct7[6]}}, s_view.funct7,
					s_view.imm_lo};
			default:
				imm_d = '0;
		endcase
	end

	always_comb begin
		case (i_view.funct3[1:0])
			2'b00:   size_d = contract_pkg::SIZE_BYTE;
			2'b01:   size_d = contract_pkg::SIZE_HALF;
			default: size_d = contract_pkg::SIZE_WORD;
		endcase
	end

	always_comb begin
		case (i_view.funct3)
			3'b001:  br_op_d = contract_pkg::BR_NE;
			3'b100:  br_op_d = contract_pkg::BR_LT;
			3'b101:  br_op_d = contract_pkg::BR_GE;
			3'b110:  br_op_d = contract_pkg::BR_LTU;
			3'b111:  br_op_d = contract_pkg::BR_GEU;
			default: br_op_d = contract_pkg::BR_EQ;
		endcase
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			kind_q <= contract_pkg::OBS_OTHER;
		end else if (load_i) begin
			kind_q <= kind_d;
		end
	end

	always_ff @(posedge clk_i) begin
		if (load_i) begin
			size_q  <= size_d;
			br_op_q <= br_op_d;
			imm_q   <= imm_d;
			pc_q    <= rec_i.pc;
			rs1_q   <= rec_i.rs1_val;
			rs2_q   <= rec_i.rs2_val;
		end
	end

	assign dec_o = '{kind: kind_q, size: size_q, br_op: br_op_q, imm: imm_q,
		pc: pc_q, rs1_val: rs1_q, rs2_val: rs2_q};

endmodule

/* lsu_addr_gen.sv */
`timescale 1ns/1ps

module lsu_addr_gen (
	input  contract_pkg::dec_t            dec_i,
	output logic [contract_pkg::XLEN-1:0] addr_o,
	output logic                          split_o
);

	logic [contract_pkg::XLEN-1:0] eff_addr;
	logic [1:0]                    offset;

	// rs1 plus immediate, wraps around at the top of the space
	assign eff_addr = dec_i.rs1_val + dec_i.imm;
	assign offset   = eff_addr[1:0];

	// a misaligned access needs a second bus transaction
	always_comb begin
		case (dec_i.size)
			contract_pkg::SIZE_WORD: begin
				split_o = (offset != 2'b00);
			end
			contract_pkg::SIZE_HALF: begin
				// only offset 3 crosses the word boundary
				split_o = (offset == 2'b11);
			end
			default: begin
				split_o = 1'b0;
			end
		endcase
	end

	assign addr_o = eff_addr;

endmodule

/* branch_cmp.sv */
`timescale 1ns/1ps

module branch_cmp (
	input  contract_pkg::dec_t dec_i,
	output logic               taken_o
);

	logic [contract_pkg::XLEN-1:0] diff;
	logic                          is_equal;
	logic                          is_ge;
	logic                          cmp_signed;

	// the one adder, rs1 minus rs2
	assign diff     = dec_i.rs1_val - dec_i.rs2_val;
	assign is_equal = (diff == '0);

	assign cmp_signed = (dec_i.br_op == contract_pkg::BR_LT) ||
		(dec_i.br_op == contract_pkg::BR_GE);

	always_comb begin
		if (dec_i.rs1_val[contract_pkg::XLEN-1] ==
			dec_i.rs2_val[contract_pkg::XLEN-1]) begin
			// same sign so the difference cannot overflow
			is_ge = ~diff[contract_pkg::XLEN-1];
		end else begin
			// differing signs leave rs1's top bit to decide
			is_ge = dec_i.rs1_val[contract_pkg::XLEN-1] ^ cmp_signed;
		end
	end

	always_comb begin
		case (dec_i.br_op)
			contract_pkg::BR_EQ:  taken_o = is_equal;
			contract_pkg::BR_NE:  taken_o = ~is_equal;
			contract_pkg::BR_LT:  taken_o = ~is_ge;
			contract_pkg::BR_LTU: taken_o = ~is_ge;
			contract_pkg::BR_GE:  taken_o = is_ge;
			contract_pkg::BR_GEU: taken_o = is_ge;
			default:              taken_o = 1'b0;
		endcase
	end

endmodule

/* obs_pipe_ctrl.sv */
`timescale 1ns/1ps

module obs_pipe_ctrl (
	input  logic                          clk_i,
	input  logic                          arst_n_i,
	input  logic                          in_valid_i,
	output logic                          in_ready_o,
	input  logic                          out_ready_i,
	output logic                          out_valid_o,
	output logic                          dec_load_o,
	input  contract_pkg::dec_t            dec_i,
	input  logic [contract_pkg::XLEN-1:0] addr_i,
	input  logic                          split_i,
	input  logic                          taken_i,
	output contract_pkg::obs_t            out_obs_o
);

	logic               s1_valid_q;
	logic               s2_valid_q;
	logic               s2_free;
	logic               s1_adv;
	logic               is_mem;
	logic               is_muldiv;
	contract_pkg::obs_t obs_d;
	contract_pkg::obs_t obs_q;

	// stage two can take a new item this edge
	assign s2_free = !s2_valid_q || out_ready_i;
	assign s1_adv  = s1_valid_q && s2_free;

	assign in_ready_o = !s1_valid_q || s2_free;
	assign dec_load_o = in_valid_i && in_ready_o;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			s1_valid_q <= 1'b0;
			s2_valid_q <= 1'b0;
		end else begin
			if (in_ready_o) begin
				s1_valid_q <= in_valid_i;
			end
			if (s2_free) begin
				s2_valid_q <= s1_valid_q;
			end
		end
	end

	assign is_mem = (dec_i.kind == contract_pkg::OBS_LOAD) ||
		(dec_i.kind == contract_pkg::OBS_STORE);
	assign is_muldiv = (dec_i.kind == contract_pkg::OBS_MUL) ||
		(dec_i.kind == contract_pkg::OBS_DIV);

	// fields outside the kind stay zero so nothing else leaks
	always_comb begin
		obs_d.kind    = dec_i.kind;
		obs_d.pc      = dec_i.pc;
		obs_d.addr    = is_mem ? addr_i : '0;
		obs_d.split   = is_mem && split_i;
		obs_d.taken   = (dec_i.kind == contract_pkg::OBS_BRANCH) && taken_i;
		obs_d.operand = is_muldiv ? dec_i.rs2_val : '0;
	end

	// holds while stalled, only loads when stage one moves on
	always_ff @(posedge clk_i) begin
		if (s1_adv) begin
			obs_q <= obs_d;
		end
	end

	assign out_valid_o = s2_valid_q;
	assign out_obs_o   = obs_q;

endmodule

/* contract_observer.sv */
`timescale 1ns/1ps

module contract_observer (
	input  logic                  clk_i,
	input  logic                  arst_n_i,
	input  logic                  in_valid_i,
	output logic                  in_ready_o,
	input  contract_pkg::retire_t in_rec_i,
	output logic                  out_valid_o,
	input  logic                  out_ready_i,
	output contract_pkg::obs_t    out_obs_o
);

	logic                          dec_load;
	contract_pkg::dec_t            dec;
	logic [contract_pkg::XLEN-1:0] lsu_addr;
	logic                          lsu_split;
	logic                          br_taken;

	obs_pipe_ctrl u_ctrl (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.in_valid_i  (in_valid_i),
		.in_ready_o  (in_ready_o),
		.out_ready_i (out_ready_i),
		.out_valid_o (out_valid_o),
		.dec_load_o  (dec_load),
		.dec_i       (dec),
		.addr_i      (lsu_addr),
		.split_i     (lsu_split),
		.taken_i     (br_taken),
		.out_obs_o   (out_obs_o)
	);

	// stage one register
	rv_obs_decode u_decode (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.load_i   (dec_load),
		.rec_i    (in_rec_i),
		.dec_o    (dec)
	);

	lsu_addr_gen u_addr (
		.dec_i   (dec),
		.addr_o  (lsu_addr),
		.split_o (lsu_split)
	);

	branch_cmp u_cmp (
		.dec_i   (dec),
		.taken_o (br_taken)
	);

endmodule

/* tb_contract_observer_properties.sv */
`timescale 1ns/1ps

module tb_contract_observer_properties (
	input logic               clk_i,
	input logic               arst_n_i,
	input logic               in_valid_i,
	input logic               in_ready_o,
	input logic               out_valid_o,
	input logic               out_ready_i,
	input contract_pkg::obs_t out_obs_o
);

	int unsigned fail_cnt = 0;

	no_valid_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !out_valid_o)
		else begin
			fail_cnt = fail_cnt + 1;
			$error("out_valid_o is high while reset is asserted");
		end

	ready_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> in_ready_o)
		else begin
			fail_cnt = fail_cnt + 1;
			$error("in_ready_o is low while reset is asserted");
		end

	// a waiting observation neither changes nor disappears
	hold_while_stalled: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_obs_o))
		else begin
			fail_cnt = fail_cnt + 1;
			$error("out_obs_o changed while waiting for out_ready_i");
		end

	// an accepted record moves into stage two on the next draining edge
	drain_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(in_valid_i && in_ready_o) ##1 out_ready_i |=> out_valid_o)
		else begin
			fail_cnt = fail_cnt + 1;
			$error("accepted record did not reach out_valid_o although out_ready_i was high");
		end

endmodule

bind contract_observer tb_contract_observer_properties u_props (
	.clk_i       (clk_i),
	.arst_n_i    (arst_n_i),
	.in_valid_i  (in_valid_i),
	.in_ready_o  (in_ready_o),
	.out_valid_o (out_valid_o),
	.out_ready_i (out_ready_i),
	.out_obs_o   (out_obs_o)
);

/* tb_contract_observer.sv */
`timescale 1ns/1ps

module tb_contract_observer;

	logic                  clk_i = 1'b0;
	logic                  arst_n_i;
	logic                  in_valid_i;
	logic                  in_ready_o;
	contract_pkg::retire_t in_rec_i;
	logic                  out_valid_o;
	logic                  out_ready_i;
	contract_pkg::obs_t    out_obs_o;

	contract_pkg::retire_t stim_q[$];
	contract_pkg::obs_t    exp_q[$];
	integer                seed = 32'h5161_d33d;
	int unsigned           in_idx = 0;
	int unsigned           out_cnt = 0;
	int unsigned           err_cnt = 0;
	int unsigned           cycles = 0;
	int unsigned           limit;
	bit                    timed_out;

	contract_observer DUT (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.in_valid_i  (in_valid_i),
		.in_ready_o  (in_ready_o),
		.in_rec_i    (in_rec_i),
		.out_valid_o (out_valid_o),
		.out_ready_i (out_ready_i),
		.out_obs_o   (out_obs_o)
	);

	always #20 clk_i = ~clk_i;

	// expected observation from the instruction fields
	function automatic contract_pkg::obs_t expected_obs(contract_pkg::retire_t r);
		contract_pkg::obs_t o;
		logic [31:0]        w;
		logic [31:0]        imm;
		logic [2:0]         f3;
		w = r.instr;
		f3 = w[14:12];
		o = '0;
		o.kind = contract_pkg::OBS_OTHER;
		o.pc = r.pc;
		if (w[6:0] == 7'h03 || w[6:0] == 7'h23) begin
			if (w[6:0] == 7'h23) begin
				o.kind = contract_pkg::OBS_STORE;
				imm = {{20{w[31]}}, w[31:25], w[11:7]};
			end else begin
				o.kind = contract_pkg::OBS_LOAD;
				imm = {{20{w[31]}}, w[31:20]};
			end
			o.addr = r.rs1_val + imm;
			if (f3[1:0] == 2'b10) begin
				o.split = (o.addr[1:0] != 2'b00);
			end else if (f3[1:0] == 2'b01) begin
				o.split = (o.addr[1:0] == 2'b11);
			end
		end else if (w[6:0] == 7'h63 && f3 != 3'd2 && f3 != 3'd3) begin
			o.kind = contract_pkg::OBS_BRANCH;
			case (f3)
				3'd0:    o.taken = (r.rs1_val == r.rs2_val);
				3'd1:    o.taken = (r.rs1_val != r.rs2_val);
				3'd4:    o.taken = ($signed(r.rs1_val) < $signed(r.rs2_val));
				3'd5:    o.taken = ($signed(r.rs1_val) >= $signed(r.rs2_val));
				3'd6:    o.taken = (r.rs1_val < r.rs2_val);
				default: o.taken = (r.rs1_val >= r.rs2_val);
			endcase
		end else if (w[6:0] == 7'h33 && w[31:25] == 7'h01 && (f3 == 3'd0 || f3[2])) begin
			o.kind = f3[2] ? contract_pkg::OBS_DIV : contract_pkg::OBS_MUL;
			o.operand = r.rs2_val;
		end
		return o;
	endfunction

	task automatic queue_record(input logic [31:0] instr, input logic [31:0] a,
		input logic [31:0] b);
		contract_pkg::retire_t r;
		r.pc = 32'h0000_8000 + 4 * stim_q.size();
		r.instr = instr;
		r.rs1_val = a;
		r.rs2_val = b;
		stim_q.push_back(r);
		exp_q.push_back(expected_obs(r));
	endtask

	task automatic directed_records();
		logic [31:0] op_a [5];
		logic [31:0] op_b [5];
		// equal, signs differ both ways, both negative, both positive
		op_a = '{32'd5, 32'hffff_fffd, 32'd7, 32'hffff_fff8, 32'd2};
		op_b = '{32'd5, 32'd7, 32'hffff_fffd, 32'hffff_fffe, 32'd9};
		for (int sz = 0; sz < 3; sz++) begin
			for (int off = 0; off < 4; off++) begin
				// load at imm -4 and store at imm +8 wrapping past the top
				queue_record({12'hffc, 5'd1, 1'b0, sz[1:0], 5'd2, 7'h03},
					32'h1004 + off, 32'h0);
				queue_record({7'h00, 5'd3, 5'd1, 1'b0, sz[1:0], 5'd8, 7'h23},
					32'hffff_fffc + off, 32'h55);
			end
		end
		for (int f3 = 0; f3 < 8; f3++) begin
			for (int p = 0; p < 5; p++) begin
				queue_record({7'h00, 5'd2, 5'd1, f3[2:0], 5'd0, 7'h63}, op_a[p], op_b[p]);
			end
			queue_record({7'h01, 5'd2, 5'd1, f3[2:0], 5'd3, 7'h33}, 32'h1234_5678,
				32'h8000_0000 + f3);
		end
		// plain ADD and LUI
		queue_record({7'h00, 5'd2, 5'd1, 3'b000, 5'd3, 7'h33}, 32'h1357_9bdf, 32'h2468_ace0);
		queue_record(32'habcd_e0b7, 32'h1, 32'h2);
	endtask

	task automatic random_record();
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		int unsigned k;
		w = $random(seed);
		a = $random(seed);
		b = w[20] ? a : $random(seed);
		k = {$random(seed)} % 6;
		case (k)
			0, 1: begin
				w[6:0] = (k == 0) ? 7'h03 : 7'h23;
				w[13] = w[13] & ~w[12];
			end
			2: w[6:0] = 7'h63;
			3, 4: begin
				w[31:25] = 7'h01;
				w[14:12] = (k == 3) ? 3'b000 : {1'b1, w[13:12]};
				w[6:0] = 7'h33;
			end
			default: w[6:0] = 7'h13;
		endcase
		queue_record(w, a, b);
	endtask

	// output check and input driving with random valid gaps and ready stalls
	always @(posedge clk_i) begin
		contract_pkg::obs_t exp_obs;
		if (arst_n_i) begin
			if (out_valid_o && out_ready_i) begin
				if (exp_q.size() == 0) begin
					$display("observation at %0t arrived with no record outstanding", $time);
					err_cnt = err_cnt + 1;
				end else begin
					exp_obs = exp_q.pop_front();
					out_cnt = out_cnt + 1;
					assert (out_obs_o == exp_obs) else begin
						$display("ERR %0t: observation %0d got %h expected %h", $time,
							out_cnt, out_obs_o, exp_obs);
						err_cnt = err_cnt + 1;
					end
				end
			end
			if (in_valid_i && in_ready_o) begin
				in_idx = in_idx + 1;
			end
			if (in_idx < stim_q.size() && ({$random(seed)} % 4 != 0)) begin
				in_valid_i <= 1'b1;
				in_rec_i <= stim_q[in_idx];
			end else begin
				in_valid_i <= 1'b0;
			end
			out_ready_i <= ({$random(seed)} % 4 != 0);
		end
	end

	initial begin
		arst_n_i = 1'b0;
		in_valid_i = 1'b0;
		in_rec_i = '0;
		out_ready_i = 1'b0;
		directed_records();
		// random phase
		repeat (200) begin
			random_record();
		end
		limit = 4 * stim_q.size() + 100;
		repeat (5) @(posedge clk_i);
		arst_n_i <= 1'b1;
		while (out_cnt < stim_q.size() && cycles < limit) begin
			@(posedge clk_i);
			cycles = cycles + 1;
		end
		timed_out = (out_cnt < stim_q.size());
		if (timed_out) begin
			$display("timeout after %0d cycles with %0d of %0d observations received",
				cycles, out_cnt, stim_q.size());
		end
		repeat (2) @(posedge clk_i);
		$display("records %0d, observations %0d, value errors %0d, assertion failures %0d",
			stim_q.size(), out_cnt, err_cnt, DUT.u_props.fail_cnt);
		if (!timed_out && err_cnt == 0 && DUT.u_props.fail_cnt == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* verilog.f */
contract_pkg.sv
rv_obs_decode.sv
lsu_addr_gen.sv
branch_cmp.sv
obs_pipe_ctrl.sv
contract_observer.sv
tb_contract_observer_properties.sv
tb_contract_observer.sv
